/* sources.f */
+incdir+tb
hdl/rr_pkg.sv
hdl/rr_digit_value.sv
hdl/rrp_mult.sv
hdl/rr_digit_recode.sv
hdl/rr_latency_timer.sv
hdl/rr_seq_ctrl.sv
hdl/rr_mult_top.sv
tb/tb_rr_mult.sv

/* run.sh */
#!/usr/bin/env bash
# build the signed-digit multiplier testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_rr_mult \
	-f sources.f -o sim_rr_mult
./obj_dir/sim_rr_mult | tee sim.log
if grep -q "All tests passed" sim.log; then
	echo "simulation result: pass"
else
	echo "simulation result: fail"
	exit 1
fi

/* tb/tb_rr_tasks.svh */
// testbench helpers: reference model, xorshift generator, multiply and check, directed tests
`ifndef TB_RR_TASKS_SVH
`define TB_RR_TASKS_SVH

// xorshift32 on the shared generator state
function automatic int unsigned next_rand();
	rng_state ^= rng_state << 13;
	rng_state ^= rng_state >> 17;
	rng_state ^= rng_state << 5;
	return rng_state;
endfunction

// operand value, digit i weighs 4**i
function automatic int digits_value(input logic [OP_BITS-1:0] d);
	logic signed [DIGIT_BITS-1:0] dig;
	int sum;
	sum = 0;
	for (int i = 0; i < OP_DIGITS; i++) begin
		dig = d[i*DIGIT_BITS +: DIGIT_BITS];
		sum += int'(dig) * (4 ** i);
	end
	return sum;
endfunction

// expected result digits, each -2..+1, low digit first
function automatic logic [RES_BITS-1:0] recode_model(input int v);
	logic [RES_BITS-1:0] res;
	int r;
	int d;
	res = '0;
	for (int i = 0; i < RES_DIGITS; i++) begin
		// remainder 0..3 for either sign of v
		r = ((v % 4) + 4) % 4;
		d = (r >= 2) ? r - 4 : r;
		res[i*DIGIT_BITS +: DIGIT_BITS] = d[DIGIT_BITS-1:0];
		// v - d is a multiple of 4, so this divides exactly
		v = (v - d) / 4;
	end
	return res;
endfunction

// random operand, every digit in -3..+3
function automatic logic [OP_BITS-1:0] rand_digits();
	logic [OP_BITS-1:0] d;
	int dig;
	for (int i = 0; i < OP_DIGITS; i++) begin
		dig = int'(next_rand() % 7) - 3;
		d[i*DIGIT_BITS +: DIGIT_BITS] = dig[DIGIT_BITS-1:0];
	end
	return d;
endfunction

function automatic bit digits_in_range(input logic [RES_BITS-1:0] p);
	logic signed [DIGIT_BITS-1:0] dig;
	for (int i = 0; i < RES_DIGITS; i++) begin
		dig = p[i*DIGIT_BITS +: DIGIT_BITS];
		if (dig < -2 || dig > 1) begin
			return 1'b0;
		end
	end
	return 1'b1;
endfunction

// one line per finished test
task automatic finish_test(input string name, input int errors);
	if (errors == 0) begin
		pass_count++;
		$display("test %s: ok", name);
	end else begin
		fail_count++;
		$display("test %s: failed with %0d errors", name, errors);
	end
endtask

// one multiply, edges counts from the edge that samples start;
// with spurious set, a second start is pulsed one edge later
task automatic check_op(input string name, input logic [OP_BITS-1:0] x,
	input logic [OP_BITS-1:0] y, input bit spurious, inout int errors, output int edges);
	logic [RES_BITS-1:0] expected;
	expected = recode_model(digits_value(x) * digits_value(y));
	@(posedge clock);
	#DRIVE_DELAY;
	x_digits = x;
	y_digits = y;
	start = 1'b1;
	@(posedge clock);
	#DRIVE_DELAY;
	start = 1'b0;
	edges = 1;
	while (!done) begin
		if (edges >= TIMEOUT_EDGES) begin
			$display("%s: done did not arrive within %0d cycles", name, TIMEOUT_EDGES);
			errors++;
			return;
		end
		if (!busy) begin
			$display("%s: busy low while the result is pending", name);
			errors++;
		end
		@(posedge clock);
		#DRIVE_DELAY;
		edges++;
		if (spurious && edges == 2) begin
			// other operands, must not reach the result
			x_digits = 12'o5555;
			y_digits = 12'o3333;
			start = 1'b1;
		end else begin
			start = 1'b0;
		end
	end
	if (p_digits !== expected) begin
		$display("ERROR %s: expected %h, actual %h", name, expected, p_digits);
		errors++;
	end
	if (!digits_in_range(p_digits)) begin
		$display("%s: a result digit lies outside -2..+1", name);
		errors++;
	end
endtask

task automatic test_reset();
	int errors;
	errors = 0;
	if (done !== 1'b0 || busy !== 1'b0) begin
		$display("ERROR reset: expected done 0 busy 0, actual done %b busy %b", done, busy);
		errors++;
	end
	if (p_digits !== '0) begin
		$display("ERROR reset: expected %h, actual %h", {RES_BITS{1'b0}}, p_digits);
		errors++;
	end
	finish_test("reset", errors);
endtask

task automatic test_fixed();
	int errors;
	int edges;
	errors = 0;
	check_op("fixed zero left", 12'o0000, 12'o1357, 1'b0, errors, edges);
	check_op("fixed zero right", 12'o3615, 12'o0000, 1'b0, errors, edges);
	check_op("fixed one", 12'o0001, 12'o0001, 1'b0, errors, edges);
	check_op("fixed plus3 squared", 12'o3333, 12'o3333, 1'b0, errors, edges);
	check_op("fixed plus3 minus3", 12'o3333, 12'o5555, 1'b0, errors, edges);
	finish_test("fixed", errors);
endtask

task automatic test_timing();
	int errors;
	int edges;
	errors = 0;
	check_op("timing", 12'o6071, 12'o0213, 1'b0, errors, edges);
	if (edges != LATENCY_EDGES) begin
		$display("ERROR timing: expected %0d edges, actual %0d", LATENCY_EDGES, edges);
		errors++;
	end
	// busy still covers the done cycle
	if (!busy) begin
		$display("timing: busy low in the done cycle");
		errors++;
	end
	@(posedge clock);
	#DRIVE_DELAY;
	// done is a single cycle and busy ends with it
	if (done || busy) begin
		$display("timing: done or busy still high one cycle after done");
		errors++;
	end
	finish_test("timing", errors);
endtask

task automatic test_redundant();
	int errors;
	int edges;
	logic [RES_BITS-1:0] first;
	errors = 0;
	// digits 1,-2 and 0,2 both stand for 2
	check_op("redundant a", 12'o0016, 12'o3172, 1'b0, errors, edges);
	first = p_digits;
	check_op("redundant b", 12'o0002, 12'o3172, 1'b0, errors, edges);
	if (p_digits !== first) begin
		$display("ERROR redundant: expected %h, actual %h", first, p_digits);
		errors++;
	end
	finish_test("redundant", errors);
endtask

task automatic test_hold();
	int errors;
	int edges;
	logic [RES_BITS-1:0] held;
	errors = 0;
	check_op("hold", 12'o3210, 12'o0123, 1'b1, errors, edges);
	if (edges != LATENCY_EDGES) begin
		$display("ERROR hold: expected %0d edges, actual %0d", LATENCY_EDGES, edges);
		errors++;
	end
	held = p_digits;
	repeat (5) begin
		@(posedge clock);
		#DRIVE_DELAY;
		if (p_digits !== held) begin
			$display("ERROR hold: expected %h, actual %h", held, p_digits);
			errors++;
		end
		if (done) begin
			$display("hold: the ignored start produced a second done");
			errors++;
		end
	end
	finish_test("hold", errors);
endtask

task automatic test_random();
	int errors;
	int edges;
	errors = 0;
	for (int n = 0; n < RANDOM_PAIRS; n++) begin
		check_op("random", rand_digits(), rand_digits(), 1'b0, errors, edges);
	end
	finish_test("random", errors);
endtask

`endif

/* tb/tb_rr_mult.sv */
// testbench top: clock, reset, DUT instance, directed test sequence and summary
`default_nettype none

module tb_rr_mult;

	import rr_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int DRIVE_DELAY = 1;
	localparam int RESET_CYCLES = 3;
	// from the start sampling edge through the edge that raises done, inclusive
	localparam int LATENCY_EDGES = 7;
	localparam int TIMEOUT_EDGES = 40;
	localparam int RANDOM_PAIRS = 200;
	localparam int unsigned SEED = 87918;

	logic                clock;
	logic                rst_n;
	logic                start;
	logic [OP_BITS-1:0]  x_digits;
	logic [OP_BITS-1:0]  y_digits;
	logic                busy;
	logic                done;
	logic [RES_BITS-1:0] p_digits;

	// generator state and per test tallies
	int unsigned rng_state;
	int          pass_count;
	int          fail_count;

	rr_mult_top UUT (
		.clock    (clock),
		.rst_n    (rst_n),
		.start    (start),
		.x_digits (x_digits),
		.y_digits (y_digits),
		.busy     (busy),
		.done     (done),
		.p_digits (p_digits)
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	`include "tb_rr_tasks.svh"

	initial begin
		rst_n = 1'b0;
		start = 1'b0;
		x_digits = '0;
		y_digits = '0;
		rng_state = SEED;
		pass_count = 0;
		fail_count = 0;
		// synchronous reset over the first edges
		repeat (RESET_CYCLES) @(posedge clock);
		#DRIVE_DELAY;
		rst_n = 1'b1;
		test_reset();
		test_fixed();
		test_timing();
		test_redundant();
		test_hold();
		test_random();
		$display("tests run: %0d, ok: %0d, failed: %0d", pass_count + fail_count,
			pass_count, fail_count);
		if (fail_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* hdl/rr_mult_top.sv */
// rr_mult_top: signed-digit multiplier unit, converters, multiplier, recoder, timer, FSM
`default_nettype none

module rr_mult_top (
	input  logic                        clock,
	input  logic                        rst_n,
	input  logic                        start,
	input  logic [rr_pkg::OP_BITS-1:0]  x_digits,
	input  logic [rr_pkg::OP_BITS-1:0]  y_digits,
	output logic                        busy,
	output logic                        done,
	output logic [rr_pkg::RES_BITS-1:0] p_digits
);

	import rr_pkg::*;

	// operand integers
	logic signed [INT_BITS-1:0]  x_int;
	logic signed [INT_BITS-1:0]  y_int;
	// pipelined product
	logic signed [PROD_BITS-1:0] prod;
	// control between FSM, timer and recoder
	logic                        timer_load;
	logic                        expired;
	logic                        res_load;

	rr_digit_value u_x_value (
		.digits (x_digits),
		.value  (x_int)
	);

	rr_digit_value u_y_value (
		.digits (y_digits),
		.value  (y_int)
	);

	// samples every edge, FSM picks the right output slot
	rrp_mult u_mult (
		.clock (clock),
		.x_in  (x_int),
		.y_in  (y_int),
		.p_out (prod)
	);

	rr_digit_recode u_recode (
		.clock    (clock),
		.rst_n    (rst_n),
		.load     (res_load),
		.prod     (prod),
		.p_digits (p_digits)
	);

	rr_latency_timer u_timer (
		.clock   (clock),
		.rst_n   (rst_n),
		.load    (timer_load),
		.expired (expired)
	);

	rr_seq_ctrl u_ctrl (
		.clock      (clock),
		.rst_n      (rst_n),
		.start      (start),
		.expired    (expired),
		.timer_load (timer_load),
		.res_load   (res_load),
		.busy       (busy),
		.done       (done)
	);

endmodule

`default_nettype wire

/* hdl/rr_seq_ctrl.sv */
// rr_seq_ctrl: idle/run/finish FSM for timer load, result load, busy and done
`default_nettype none

module rr_seq_ctrl (
	input  logic clock,
	input  logic rst_n,
	input  logic start,
	input  logic expired,
	output logic timer_load,
	output logic res_load,
	output logic busy,
	output logic done
);

	// one flop per active state, idle when both are low
	logic run_q;
	logic fin_q;
	logic idle;

	assign idle = !run_q && !fin_q;

	// start only counts in idle
	assign timer_load = idle && start;

	// product on the multiplier output, capture it
	assign res_load = run_q && expired;

	assign busy = run_q || fin_q;

	// finish lasts one cycle
	assign done = fin_q;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			run_q <= 1'b0;
			fin_q <= 1'b0;
		end else begin
			// enter run on accept, stay until capture
			run_q <= timer_load || (run_q && !expired);
			// finish right after capture, then idle
			fin_q <= res_load;
		end
	end

	a_done_pulse: assert property (
		@(posedge clock) disable iff (!rst_n)
		done |=> !done
	) else $error("rr_seq_ctrl: done held for more than one cycle");

	// expiry must land while a product is pending
	a_expire_in_run: assert property (
		@(posedge clock) disable iff (!rst_n)
		expired |-> run_q
	) else $error("rr_seq_ctrl: timer expired outside run");

endmodule

`default_nettype wire

/* hdl/rr_latency_timer.sv */
// rr_latency_timer: down-counter over the multiplier pipeline depth, expiry flag
`default_nettype none

module rr_latency_timer (
	input  logic clock,
	input  logic rst_n,
	input  logic load,
	output logic expired
);

	import rr_pkg::*;

	// cycles left until the product shows
	logic [TIMER_BITS-1:0] count;
	// counting, cleared after expiry
	logic                  active;

	// single cycle flag at zero
	assign expired = active && (count == '0);

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			active <= 1'b0;
			count  <= '0;
		end else if (load) begin
			active <= 1'b1;
			// load edge counts as the first pipeline edge
			count  <= TIMER_BITS'(PIPE_DEPTH - 1);
		end else if (active) begin
			if (count == '0) begin
				// back to idle
				active <= 1'b0;
			end else begin
				count <= count - 1'b1;
			end
		end
	end

	a_count_bound: assert property (
		@(posedge clock) disable iff (!rst_n)
		count <= TIMER_BITS'(PIPE_DEPTH - 1)
	) else $error("rr_latency_timer: count above pipeline depth");

endmodule

`default_nettype wire

/* hdl/rr_digit_recode.sv */
// rr_digit_recode: product to nine radix-4 digits in -2..+1, result holding register
`default_nettype none

module rr_digit_recode (
	input  logic                                clock,
	input  logic                                rst_n,
	input  logic                                load,
	input  logic signed [rr_pkg::PROD_BITS-1:0] prod,
	output logic [rr_pkg::RES_BITS-1:0]         p_digits
);

	import rr_pkg::*;

	// running quotient
	logic signed [PROD_BITS-1:0] q;
	// remainder mod 4, always 0..3
	logic [DIGIT_BITS-2:0]       r;
	// recoded digits before capture
	logic [RES_BITS-1:0]         digits_next;
	// per digit range flags
	logic [RES_DIGITS-1:0]       digit_ok;
	// weighted value of the held digits
	logic signed [PROD_BITS-1:0] held_value;

	// digit extraction from the low end
	always_comb begin
		q = prod;
		for (int i = 0; i < RES_DIGITS; i++) begin
			// low bits give the remainder even for negative q
			r = q[DIGIT_BITS-2:0];
			// r of 2 or 3 becomes r - 4, i.e. top bit of r copied up
			digits_next[i*DIGIT_BITS +: DIGIT_BITS] = {r[DIGIT_BITS-2], r};
			// arithmetic shift = floor divide by 4
			q = q >>> (DIGIT_BITS - 1);
			// negative digit borrows, so carry one into the quotient
			if (r[DIGIT_BITS-2]) begin
				q = q + 1;
			end
		end
	end

	// hold result until next load
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			p_digits <= '0;
		end else if (load) begin
			p_digits <= digits_next;
		end
	end

	// -2..+1 in 3 bits means the two top bits agree
	for (genvar i = 0; i < RES_DIGITS; i++) begin : g_chk
		assign digit_ok[i] = p_digits[i*DIGIT_BITS + DIGIT_BITS - 1]
			== p_digits[i*DIGIT_BITS + DIGIT_BITS - 2];
	end

	// top digit first, each step times 4 plus the next digit
	always_comb begin
		held_value = '0;
		for (int i = RES_DIGITS - 1; i >= 0; i--) begin
			held_value = (held_value <<< (DIGIT_BITS - 1))
				+ signed'(p_digits[i*DIGIT_BITS +: DIGIT_BITS]);
		end
	end

	a_digit_range: assert property (
		@(posedge clock) disable iff (!rst_n)
		&digit_ok
	) else $error("rr_digit_recode: held digit outside -2..+1");

	// held digits add up to the product seen on load
	a_digit_value: assert property (
		@(posedge clock) disable iff (!rst_n)
		$past(load) |-> held_value == $past(prod)
	) else $error("rr_digit_recode: held digits do not add up to the loaded product");

endmodule

`default_nettype wire

/* hdl/rrp_mult.sv */
// rrp_mult: pipelined multiplier with input regs, product reg, delay buffer, output reg
`default_nettype none

module rrp_mult (
	input  logic                                clock,
	input  logic signed [rr_pkg::INT_BITS-1:0]  x_in,
	input  logic signed [rr_pkg::INT_BITS-1:0]  y_in,
	output logic signed [rr_pkg::PROD_BITS-1:0] p_out
);

	import rr_pkg::*;

	// operand capture
	logic signed [INT_BITS-1:0]  x_reg;
	logic signed [INT_BITS-1:0]  y_reg;

	// entry 0 is the product register, the rest are delay
	logic signed [PROD_BITS-1:0] p_buf [BUF_STAGES];

	// free running, one new pair per clock
	always_ff @(posedge clock) begin
		x_reg <= x_in;
		y_reg <= y_in;
		// operands widened to product width before multiply
		p_buf[0] <= x_reg * y_reg;
		for (int j = 1; j < BUF_STAGES; j++) begin
			p_buf[j] <= p_buf[j-1];
		end
		p_out <= p_buf[BUF_STAGES-1];
	end

	// output equals the product of the pair seen PIPE_DEPTH edges back,
	// checked once that history holds known values
	a_pipe_product: assert property (
		@(posedge clock)
		!$isunknown({$past(x_in, PIPE_DEPTH), $past(y_in, PIPE_DEPTH)})
		|-> p_out == $past(x_in, PIPE_DEPTH) * $past(y_in, PIPE_DEPTH)
	) else $error("rrp_mult: product does not match operands %0d cycles back",
		PIPE_DEPTH);

endmodule

`default_nettype wire

/* hdl/rr_digit_value.sv */
// rr_digit_value: signed-digit operand vector to two's complement integer
`default_nettype none

module rr_digit_value (
	input  logic [rr_pkg::OP_BITS-1:0]         digits,
	output logic signed [rr_pkg::INT_BITS-1:0] value
);

	import rr_pkg::*;

	// weighted digit terms
	logic signed [INT_BITS-1:0] term [OP_DIGITS];

	for (genvar i = 0; i < OP_DIGITS; i++) begin : g_term
		// raw digit, -3..+3
		logic signed [DIGIT_BITS-1:0] d;
		// digit sign-extended to integer width
		logic signed [INT_BITS-1:0]   d_ext;

		assign d = digits[i*DIGIT_BITS +: DIGIT_BITS];
		// signed source, so this extends the sign
		assign d_ext = d;
		// weight 4**i as a left shift by 2*i
		assign term[i] = d_ext <<< ((DIGIT_BITS - 1) * i);
	end

	// sum of all weighted digits
	always_comb begin
		value = '0;
		for (int i = 0; i < OP_DIGITS; i++) begin
			value = value + term[i];
		end
	end

endmodule

`default_nettype wire

/* hdl/rr_pkg.sv */
// rr_pkg: digit format, operand and result widths, multiplier pipeline depth
`default_nettype none

package rr_pkg;

	// radix 4 signed digits
	localparam int RADIX = 4;

	// digits per operand
	localparam int OP_DIGITS = 4;

	// two's complement digit, one bit wider than log2 of the radix
	localparam int DIGIT_BITS = $clog2(RADIX) + 1;

	// operand digit vector, digit 0 in the low bits
	localparam int OP_BITS = OP_DIGITS * DIGIT_BITS;

	// operand as integer, covers +-255
	localparam int INT_BITS = 10;

	// result needs one digit more than the plain product
	localparam int RES_DIGITS = 2 * OP_DIGITS + 1;
	localparam int RES_BITS = RES_DIGITS * DIGIT_BITS;

	// product kept at result vector width
	localparam int PROD_BITS = RES_BITS;

	// product delay buffer entries
	localparam int BUF_STAGES = 4;

	// input reg + product reg + three shifts + output reg
	localparam int PIPE_DEPTH = BUF_STAGES + 2;

	// latency counter width
	localparam int TIMER_BITS = $clog2(PIPE_DEPTH);

endpackage

`default_nettype wire
